// File: pipe_ctrl.f
design/pipe_ctrl_pkg.sv
design/redirect_unit.sv
design/hazard_detect.sv
design/pipe_arbiter.sv
design/pipe_ctrl.sv
dv/pipe_ctrl_sva.sv
dv/tb_pipe_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pipe_ctrl \
    --Mdir obj_dir \
    -f pipe_ctrl.f

# Keep running past assertion errors so the closing status line is printed
output=$(./obj_dir/Vtb_pipe_ctrl +verilator+error+limit+100000) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: dv/tb_pipe_ctrl.sv
`timescale 1ns/1ps

module tb_pipe_ctrl;

    logic                                 clock;
    logic                                 rst_n;
    pipe_ctrl_pkg::stage_info_t           id_stage;
    pipe_ctrl_pkg::stage_info_t           ex_stage;
    pipe_ctrl_pkg::stage_info_t           mem_stage;
    pipe_ctrl_pkg::stage_info_t           wb_stage;
    logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs1;
    logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs2;
    logic                                 id_mret;
    logic                                 id_ecall;
    logic                                 ex_jump;
    logic                                 ex_branch;
    logic                                 ex_fence_i;
    logic [pipe_ctrl_pkg::xlen-1:0]       ex_pc;
    logic [pipe_ctrl_pkg::xlen-1:0]       ex_imm;
    pipe_ctrl_pkg::fwd_data_t             fwd_data;
    logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs1;
    logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs2;
    logic [pipe_ctrl_pkg::xlen-1:0]       mtvec;
    logic [pipe_ctrl_pkg::xlen-1:0]       mepc;
    logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs1_in;
    logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs2_in;
    logic [pipe_ctrl_pkg::xlen-1:0]       dnpc;
    logic                                 dnpc_valid;
    logic                                 id_flush;
    logic                                 icache_clr;
    logic                                 stall;

    logic [15:0] lfsr_state;
    int          timeouts;

    pipe_ctrl UUT (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Indices 0 to 3 so stages collide often
    function automatic logic [pipe_ctrl_pkg::reg_addr_w-1:0] rand_reg();
        logic [31:0] v;
        v = rand_bits(2);
        return v[pipe_ctrl_pkg::reg_addr_w-1:0];
    endfunction

    function automatic pipe_ctrl_pkg::stage_info_t rand_stage();
        pipe_ctrl_pkg::stage_info_t st;
        logic [31:0]                v;
        v          = rand_bits(3);
        st.valid   = v[0];
        st.reg_wen = v[1];
        st.mem_ren = v[2];
        st.rd      = rand_reg();
        return st;
    endfunction

    function automatic logic rare_flag();
        return rand_bits(3) == 32'd0;  // One in eight
    endfunction

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic set_causes(input logic [4:0] mask);
        ex_jump    = mask[0];
        ex_branch  = mask[1];
        id_mret    = mask[2];
        id_ecall   = mask[3];
        ex_fence_i = mask[4];
    endtask

    task automatic clear_inputs();
        id_stage           = '0;
        ex_stage           = '0;
        mem_stage          = '0;
        wb_stage           = '0;
        id_rs1             = '0;
        id_rs2             = '0;
        set_causes(5'b0);
        ex_pc              = 32'h0000_1000;
        ex_imm             = 32'h0000_0040;
        fwd_data.ex_result = 32'h0000_2001;  // Bit 0 set, branch taken
        fwd_data.mem_alu   = 32'h0000_3000;
        fwd_data.mem_rdata = 32'h0000_4000;
        fwd_data.wb_value  = 32'h0000_5000;
        rf_rs1             = 32'h0000_0101;
        rf_rs2             = 32'h0000_0202;
        mtvec              = 32'h8000_0000;
        mepc               = 32'h0000_0800;
    endtask

    task automatic wait_pulse(input logic on_stall, input int max_cycles);
        int   waited;
        logic seen;
        waited = 0;
        seen   = on_stall ? stall : dnpc_valid;
        while (!seen && waited < max_cycles) begin
            step();
            waited++;
            seen = on_stall ? stall : dnpc_valid;
        end
        if (!seen) begin
            timeouts++;
            if (on_stall) begin
                $display("timeout at %0t: stall never rose within %0d cycles", $time, max_cycles);
            end else begin
                $display("timeout at %0t: no redirect pulse within %0d cycles", $time, max_cycles);
            end
        end
    endtask

    task automatic fire_redirect(input logic [4:0] mask, input int extra_cycles);
        clear_inputs();
        id_stage.valid = 1'b1;
        ex_stage.valid = 1'b1;
        set_causes(mask);
        step();
        wait_pulse(1'b0, 4);
        repeat (extra_cycles) step();  // Request still held in the shadow cycle
        set_causes(5'b0);
        step();
    endtask

    task automatic place_writer(input int k);
        pipe_ctrl_pkg::stage_info_t st;
        st = '{valid: 1'b1, rd: 5'd3, reg_wen: 1'b1, mem_ren: (k == 2)};
        case (k)
            0: ex_stage = st;
            1, 2: mem_stage = st;
            3: wb_stage = st;
            default: begin
                // Every stage writes x0
                st.rd     = '0;
                ex_stage  = st;
                mem_stage = st;
                wb_stage  = st;
                id_rs1    = '0;
            end
        endcase
    endtask

    task automatic drive_random();
        id_stage           = rand_stage();
        ex_stage           = rand_stage();
        mem_stage          = rand_stage();
        wb_stage           = rand_stage();
        id_rs1             = rand_reg();
        id_rs2             = rand_reg();
        id_mret            = rare_flag();
        id_ecall           = rare_flag();
        ex_jump            = rare_flag();
        ex_branch          = rare_flag();
        ex_fence_i         = rare_flag();
        ex_pc              = rand_bits(32);
        ex_imm             = rand_bits(32);
        fwd_data.ex_result = rand_bits(32);
        fwd_data.mem_alu   = rand_bits(32);
        fwd_data.mem_rdata = rand_bits(32);
        fwd_data.wb_value  = rand_bits(32);
        rf_rs1             = rand_bits(32);
        rf_rs2             = rand_bits(32);
        mtvec              = rand_bits(32);
        mepc               = rand_bits(32);
    endtask

    initial begin
        int fail_total;
        lfsr_state = 16'd97;
        timeouts   = 0;
        rst_n      = 1'b0;
        clear_inputs();
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
        step();

        for (int i = 0; i < 5; i++) begin
            fire_redirect(5'b1 << i, 0);
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = i + 1; j < 5; j++) begin
                fire_redirect((5'b1 << i) | (5'b1 << j), 0);
            end
        end
        fire_redirect(5'b00001, 1);

        // Branch not taken
        clear_inputs();
        ex_stage.valid     = 1'b1;
        ex_branch          = 1'b1;
        fwd_data.ex_result = 32'h0000_2000;
        step();
        step();

        for (int k = 0; k < 5; k++) begin
            clear_inputs();
            id_stage.valid = 1'b1;
            id_rs1         = 5'd3;
            place_writer(k);
            step();
        end

        // Load in EXU feeding rs2
        clear_inputs();
        id_stage.valid = 1'b1;
        id_rs2         = 5'd3;
        ex_stage       = '{valid: 1'b1, rd: 5'd3, reg_wen: 1'b1, mem_ren: 1'b1};
        step();
        clear_inputs();
        wait_pulse(1'b1, 4);
        step();

        // Load-use with a jump in the same cycle
        clear_inputs();
        id_stage.valid = 1'b1;
        id_rs1         = 5'd2;
        ex_stage       = '{valid: 1'b1, rd: 5'd2, reg_wen: 1'b1, mem_ren: 1'b1};
        ex_jump        = 1'b1;
        step();
        clear_inputs();
        wait_pulse(1'b0, 4);
        step();

        repeat (2000) begin
            drive_random();
            step();
        end
        clear_inputs();
        repeat (3) step();

        fail_total = UUT.u_sva.fail_count + timeouts;
        $display("checks done: %0d assertion failures, %0d timeouts",
                 UUT.u_sva.fail_count, timeouts);
        if (fail_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/pipe_ctrl_sva.sv
`timescale 1ns/1ps

module pipe_ctrl_sva (
    input logic                                 clock,
    input logic                                 rst_n,
    input pipe_ctrl_pkg::stage_info_t           id_stage,
    input pipe_ctrl_pkg::stage_info_t           ex_stage,
    input pipe_ctrl_pkg::stage_info_t           mem_stage,
    input pipe_ctrl_pkg::stage_info_t           wb_stage,
    input logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs1,
    input logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs2,
    input logic                                 id_mret,
    input logic                                 id_ecall,
    input logic                                 ex_jump,
    input logic                                 ex_branch,
    input logic                                 ex_fence_i,
    input logic [pipe_ctrl_pkg::xlen-1:0]       ex_pc,
    input logic [pipe_ctrl_pkg::xlen-1:0]       ex_imm,
    input pipe_ctrl_pkg::fwd_data_t             fwd_data,
    input logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs1,
    input logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs2,
    input logic [pipe_ctrl_pkg::xlen-1:0]       mtvec,
    input logic [pipe_ctrl_pkg::xlen-1:0]       mepc,
    input logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs1_in,
    input logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs2_in,
    input logic [pipe_ctrl_pkg::xlen-1:0]       dnpc,
    input logic                                 dnpc_valid,
    input logic                                 id_flush,
    input logic                                 icache_clr,
    input logic                                 stall
);

    int                             fail_count = 0;
    logic                           exp_req;
    logic                           exp_fence_i;
    logic [pipe_ctrl_pkg::xlen-1:0] exp_target;
    logic [pipe_ctrl_pkg::xlen-1:0] exp_rs1;
    logic [pipe_ctrl_pkg::xlen-1:0] exp_rs2;
    logic                           exp_load_use;
    logic                           exp_shadow;
    logic                           accept;
    logic                           stall_due;

    function automatic logic writes(
        input pipe_ctrl_pkg::stage_info_t           st,
        input logic [pipe_ctrl_pkg::reg_addr_w-1:0] rs
    );
        return st.valid && st.reg_wen && (st.rd == rs) && (rs != '0);
    endfunction

    function automatic logic [pipe_ctrl_pkg::xlen-1:0] operand_for(
        input logic [pipe_ctrl_pkg::reg_addr_w-1:0] rs,
        input logic [pipe_ctrl_pkg::xlen-1:0]       rf_value
    );
        logic [pipe_ctrl_pkg::xlen-1:0] value;
        value = rf_value;
        if (writes(ex_stage, rs)) begin
            value = fwd_data.ex_result;
        end else if (writes(mem_stage, rs)) begin
            value = mem_stage.mem_ren ? fwd_data.mem_rdata : fwd_data.mem_alu;
        end else if (writes(wb_stage, rs)) begin
            value = fwd_data.wb_value;
        end
        return value;
    endfunction

    always_comb begin
        exp_req     = 1'b1;
        exp_fence_i = 1'b0;
        exp_target  = '0;
        if (ex_stage.valid && ex_jump) begin
            exp_target = fwd_data.ex_result;
        end else if (ex_stage.valid && ex_branch && fwd_data.ex_result[0]) begin
            exp_target = ex_pc + ex_imm;
        end else if (id_stage.valid && id_mret) begin
            exp_target = mepc;
        end else if (id_stage.valid && id_ecall) begin
            exp_target = mtvec;
        end else if (ex_stage.valid && ex_fence_i) begin
            exp_target  = ex_pc + 32'd4;
            exp_fence_i = 1'b1;
        end else begin
            exp_req = 1'b0;
        end
        exp_rs1      = operand_for(id_rs1, rf_rs1);
        exp_rs2      = operand_for(id_rs2, rf_rs2);
        exp_load_use = id_stage.valid && ex_stage.mem_ren &&
                       (writes(ex_stage, id_rs1) || writes(ex_stage, id_rs2));
    end

    // Shadow cycle follows every accepted redirect
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            exp_shadow <= 1'b0;
        end else begin
            exp_shadow <= accept;
        end
    end

    assign accept    = exp_req & ~exp_shadow;
    assign stall_due = exp_load_use & ~exp_req & ~exp_shadow;

    a_redirect: assert property (@(posedge clock) disable iff (!rst_n)
        accept |=> dnpc_valid && id_flush && (dnpc == $past(exp_target)))
        else begin
            fail_count++;
            $error("error at %0t: redirect pulse or dnpc target wrong", $time);
        end

    a_no_redirect: assert property (@(posedge clock) disable iff (!rst_n)
        !accept |=> !dnpc_valid && !id_flush)
        else begin
            fail_count++;
            $error("error at %0t: redirect pulse without an accepted request", $time);
        end

    // Nothing issued right after a pulse
    a_shadow: assert property (@(posedge clock) disable iff (!rst_n)
        dnpc_valid |=> !dnpc_valid && !stall)
        else begin
            fail_count++;
            $error("error at %0t: request not masked in shadow cycle", $time);
        end

    a_forward: assert property (@(posedge clock) disable iff (!rst_n)
        (ex_rs1_in == exp_rs1) && (ex_rs2_in == exp_rs2))
        else begin
            fail_count++;
            $error("error at %0t: forwarded operand wrong", $time);
        end

    a_stall: assert property (@(posedge clock) disable iff (!rst_n)
        1'b1 |=> stall == $past(stall_due))
        else begin
            fail_count++;
            $error("error at %0t: stall level wrong", $time);
        end

    a_icache: assert property (@(posedge clock) disable iff (!rst_n)
        1'b1 |=> icache_clr == $past(accept && exp_fence_i))
        else begin
            fail_count++;
            $error("error at %0t: icache clear pulse wrong", $time);
        end

    a_reset: assert property (@(posedge clock)
        !rst_n |=> !dnpc_valid && !id_flush && !icache_clr && !stall && (dnpc == '0))
        else begin
            fail_count++;
            $error("error at %0t: outputs not cleared by reset", $time);
        end

endmodule

bind pipe_ctrl pipe_ctrl_sva u_sva (.*);

// File: design/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  pipe_ctrl_pkg::stage_info_t           id_stage,
    input  pipe_ctrl_pkg::stage_info_t           ex_stage,
    input  pipe_ctrl_pkg::stage_info_t           mem_stage,
    input  pipe_ctrl_pkg::stage_info_t           wb_stage,
    input  logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs2,
    input  logic                                 id_mret,
    input  logic                                 id_ecall,
    input  logic                                 ex_jump,
    input  logic                                 ex_branch,
    input  logic                                 ex_fence_i,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_pc,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_imm,
    input  pipe_ctrl_pkg::fwd_data_t             fwd_data,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs1,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rf_rs2,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       mtvec,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       mepc,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs1_in,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs2_in,
    output logic [pipe_ctrl_pkg::xlen-1:0]       dnpc,
    output logic                                 dnpc_valid,
    output logic                                 id_flush,
    output logic                                 icache_clr,
    output logic                                 stall
);

    pipe_ctrl_pkg::redirect_t       redirect_req;
    pipe_ctrl_pkg::fwd_sel_t        fwd_req;
    logic                           branch_taken;
    logic [pipe_ctrl_pkg::xlen-1:0] ex_target;

    assign branch_taken = fwd_data.ex_result[0];  // Compare result from ALU
    assign ex_target    = fwd_data.ex_result;

    redirect_unit u_redirect (
        .id_valid     (id_stage.valid),
        .ex_valid     (ex_stage.valid),
        .id_mret      (id_mret),
        .id_ecall     (id_ecall),
        .ex_jump      (ex_jump),
        .ex_branch    (ex_branch),
        .ex_fence_i   (ex_fence_i),
        .branch_taken (branch_taken),
        .ex_target    (ex_target),
        .ex_pc        (ex_pc),
        .ex_imm       (ex_imm),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .redirect_req (redirect_req)
    );

    hazard_detect u_hazard (
        .id_rs1    (id_rs1),
        .id_rs2    (id_rs2),
        .id_stage  (id_stage),
        .ex_stage  (ex_stage),
        .mem_stage (mem_stage),
        .wb_stage  (wb_stage),
        .fwd_req   (fwd_req)
    );

    pipe_arbiter u_arbiter (
        .clock        (clock),
        .rst_n        (rst_n),
        .redirect_req (redirect_req),
        .fwd_req      (fwd_req),
        .fwd_data     (fwd_data),
        .rf_rs1       (rf_rs1),
        .rf_rs2       (rf_rs2),
        .ex_rs1_in    (ex_rs1_in),
        .ex_rs2_in    (ex_rs2_in),
        .dnpc         (dnpc),
        .dnpc_valid   (dnpc_valid),
        .id_flush     (id_flush),
        .icache_clr   (icache_clr),
        .stall        (stall)
    );

endmodule

// File: design/pipe_arbiter.sv
`timescale 1ns/1ps

module pipe_arbiter (
    input  logic                           clock,
    input  logic                           rst_n,
    input  pipe_ctrl_pkg::redirect_t       redirect_req,
    input  pipe_ctrl_pkg::fwd_sel_t        fwd_req,
    input  pipe_ctrl_pkg::fwd_data_t       fwd_data,
    input  logic [pipe_ctrl_pkg::xlen-1:0] rf_rs1,
    input  logic [pipe_ctrl_pkg::xlen-1:0] rf_rs2,
    output logic [pipe_ctrl_pkg::xlen-1:0] ex_rs1_in,
    output logic [pipe_ctrl_pkg::xlen-1:0] ex_rs2_in,
    output logic [pipe_ctrl_pkg::xlen-1:0] dnpc,
    output logic                           dnpc_valid,
    output logic                           id_flush,
    output logic                           icache_clr,
    output logic                           stall
);

    logic shadow;           // Stages hold wrong-path instructions this cycle
    logic redirect_accept;
    logic stall_set;
    logic fence_i_accept;

    function automatic logic [pipe_ctrl_pkg::xlen-1:0] mux_operand(
        input pipe_ctrl_pkg::fwd_sel_e       sel,
        input pipe_ctrl_pkg::fwd_data_t      data,
        input logic [pipe_ctrl_pkg::xlen-1:0] rf_value
    );
        logic [pipe_ctrl_pkg::xlen-1:0] value;
        case (sel)
            pipe_ctrl_pkg::fwd_ex_alu:   value = data.ex_result;
            pipe_ctrl_pkg::fwd_wb:       value = data.wb_value;
            pipe_ctrl_pkg::fwd_mem_load: value = data.mem_rdata;
            pipe_ctrl_pkg::fwd_mem_alu:  value = data.mem_alu;
            default:                     value = rf_value;
        endcase
        return value;
    endfunction

    // Forwarded operands go straight through
    assign ex_rs1_in = mux_operand(fwd_req.rs1_sel, fwd_data, rf_rs1);
    assign ex_rs2_in = mux_operand(fwd_req.rs2_sel, fwd_data, rf_rs2);

    assign redirect_accept = redirect_req.valid & ~shadow;
    assign fence_i_accept  = redirect_accept &
                             (redirect_req.cause == pipe_ctrl_pkg::rd_fence_i);
    // Redirect wins over a stall
    assign stall_set       = fwd_req.load_use & ~redirect_req.valid & ~shadow;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            shadow     <= 1'b0;
            icache_clr <= 1'b0;
            stall      <= 1'b0;
            dnpc       <= '0;
        end else begin
            shadow     <= redirect_accept;  // One-cycle pulse, also masks next cycle
            icache_clr <= fence_i_accept;
            stall      <= stall_set;
            if (redirect_accept) begin
                dnpc <= redirect_req.target;
            end
        end
    end

    // Pulse and flush come from the same flop
    assign dnpc_valid = shadow;
    assign id_flush   = shadow;

endmodule

// File: design/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect (
    input  logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [pipe_ctrl_pkg::reg_addr_w-1:0] id_rs2,
    input  pipe_ctrl_pkg::stage_info_t           id_stage,
    input  pipe_ctrl_pkg::stage_info_t           ex_stage,
    input  pipe_ctrl_pkg::stage_info_t           mem_stage,
    input  pipe_ctrl_pkg::stage_info_t           wb_stage,
    output pipe_ctrl_pkg::fwd_sel_t              fwd_req
);

    logic rs1_ex_hit;
    logic rs2_ex_hit;
    logic rs1_ex_load;
    logic rs2_ex_load;

    // Stage writes the register we read; x0 never matches
    function automatic logic stage_hit(
        input pipe_ctrl_pkg::stage_info_t           st,
        input logic [pipe_ctrl_pkg::reg_addr_w-1:0] rs
    );
        return st.valid && st.reg_wen && (st.rd == rs) && (rs != '0);
    endfunction

    // Youngest producer wins
    function automatic pipe_ctrl_pkg::fwd_sel_e pick_source(
        input logic [pipe_ctrl_pkg::reg_addr_w-1:0] rs,
        input pipe_ctrl_pkg::stage_info_t           ex_st,
        input pipe_ctrl_pkg::stage_info_t           mem_st,
        input pipe_ctrl_pkg::stage_info_t           wb_st
    );
        pipe_ctrl_pkg::fwd_sel_e sel;
        sel = pipe_ctrl_pkg::fwd_rf;
        if (stage_hit(ex_st, rs)) begin
            sel = pipe_ctrl_pkg::fwd_ex_alu;
        end else if (stage_hit(mem_st, rs)) begin
            if (mem_st.mem_ren) begin
                sel = pipe_ctrl_pkg::fwd_mem_load;  // Load data back from memory
            end else begin
                sel = pipe_ctrl_pkg::fwd_mem_alu;
            end
        end else if (stage_hit(wb_st, rs)) begin
            sel = pipe_ctrl_pkg::fwd_wb;
        end
        return sel;
    endfunction

    assign rs1_ex_hit = stage_hit(ex_stage, id_rs1);
    assign rs2_ex_hit = stage_hit(ex_stage, id_rs2);

    // A load in EXU has no data to forward yet
    assign rs1_ex_load = rs1_ex_hit & ex_stage.mem_ren;
    assign rs2_ex_load = rs2_ex_hit & ex_stage.mem_ren;

    always_comb begin
        fwd_req.rs1_sel  = pick_source(id_rs1, ex_stage, mem_stage, wb_stage);
        fwd_req.rs2_sel  = pick_source(id_rs2, ex_stage, mem_stage, wb_stage);
        fwd_req.load_use = id_stage.valid & (rs1_ex_load | rs2_ex_load);
    end

endmodule

// File: design/redirect_unit.sv
`timescale 1ns/1ps

module redirect_unit (
    input  logic                             id_valid,
    input  logic                             ex_valid,
    input  logic                             id_mret,
    input  logic                             id_ecall,
    input  logic                             ex_jump,
    input  logic                             ex_branch,
    input  logic                             ex_fence_i,
    input  logic                             branch_taken,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   ex_target,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   ex_pc,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   ex_imm,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   mtvec,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   mepc,
    output pipe_ctrl_pkg::redirect_t         redirect_req
);

    logic                           jump_hit;
    logic                           branch_hit;
    logic                           mret_hit;
    logic                           ecall_hit;
    logic                           fence_i_hit;
    logic [pipe_ctrl_pkg::xlen-1:0] branch_target;
    logic [pipe_ctrl_pkg::xlen-1:0] fence_i_target;

    // Causes only count when their stage holds a live instruction
    assign jump_hit    = ex_jump & ex_valid;
    assign branch_hit  = ex_branch & ex_valid & branch_taken;
    assign mret_hit    = id_mret & id_valid;
    assign ecall_hit   = id_ecall & id_valid;
    assign fence_i_hit = ex_fence_i & ex_valid;

    assign branch_target  = ex_pc + ex_imm;
    assign fence_i_target = ex_pc + pipe_ctrl_pkg::inst_bytes;  // Restart after fence.i

    // Fixed priority, EXU causes ahead of IDU ones except fence.i
    always_comb begin
        redirect_req        = '0;
        redirect_req.cause  = pipe_ctrl_pkg::rd_none;
        if (jump_hit) begin
            redirect_req.valid  = 1'b1;
            redirect_req.cause  = pipe_ctrl_pkg::rd_jump;
            redirect_req.target = ex_target;  // jal/jalr address from ALU
        end else if (branch_hit) begin
            redirect_req.valid  = 1'b1;
            redirect_req.cause  = pipe_ctrl_pkg::rd_branch;
            redirect_req.target = branch_target;
        end else if (mret_hit) begin
            redirect_req.valid  = 1'b1;
            redirect_req.cause  = pipe_ctrl_pkg::rd_mret;
            redirect_req.target = mepc;
        end else if (ecall_hit) begin
            redirect_req.valid  = 1'b1;
            redirect_req.cause  = pipe_ctrl_pkg::rd_ecall;
            redirect_req.target = mtvec;  // Trap vector
        end else if (fence_i_hit) begin
            redirect_req.valid  = 1'b1;
            redirect_req.cause  = pipe_ctrl_pkg::rd_fence_i;
            redirect_req.target = fence_i_target;
        end
    end

endmodule

// File: design/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Return address step for fence.i
    localparam logic [xlen-1:0] inst_bytes = xlen'(4);

    // Status of one pipeline stage
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_wen;
        logic                  mem_ren;  // Load in flight
    } stage_info_t;

    // Operand source codes
    typedef enum logic [2:0] {
        fwd_rf       = 3'd0,
        fwd_ex_alu   = 3'd1,
        fwd_wb       = 3'd2,
        fwd_mem_load = 3'd3,
        fwd_mem_alu  = 3'd4
    } fwd_sel_e;

    typedef enum logic [2:0] {
        rd_none    = 3'd0,
        rd_jump    = 3'd1,
        rd_branch  = 3'd2,
        rd_mret    = 3'd3,
        rd_ecall   = 3'd4,
        rd_fence_i = 3'd5
    } redirect_cause_e;

    typedef struct packed {
        logic              valid;
        redirect_cause_e   cause;
        logic [xlen-1:0]   target;
    } redirect_t;

    typedef struct packed {
        fwd_sel_e rs1_sel;
        fwd_sel_e rs2_sel;
        logic     load_use;  // Operand not produced yet
    } fwd_sel_t;

    // Values that can be forwarded into EXU
    typedef struct packed {
        logic [xlen-1:0] ex_result;
        logic [xlen-1:0] mem_alu;
        logic [xlen-1:0] mem_rdata;
        logic [xlen-1:0] wb_value;
    } fwd_data_t;

endpackage
